//--- Makefile
TOP := tb_uart

.PHONY: lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "All tests passed" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- sim.f
+incdir+src
+incdir+tb
src/uart_pkg.sv
src/baud_tick_gen.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart.sv
tb/tb_uart.sv

//--- src/baud_tick_gen.sv
`timescale 1ns/1ns
`include "uart_settings.svh"

module baud_tick_gen (
	input  logic clk,
	input  logic reset,
	output logic o_tick
);

	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int CNT_W = (CLKS > 2) ? $clog2(CLKS) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS - 1);

	logic [CNT_W-1:0] count_q;

	// free running, no relation to frame starts
	always_ff @(posedge clk) begin
		if (reset) begin
			count_q <= '0;
		end else if (o_tick) begin
			count_q <= '0;  // wrap
		end else begin
			count_q <= count_q + 1'b1;
		end
	end

	assign o_tick = (count_q == LAST);

endmodule

//--- src/uart.sv
`timescale 1ns/1ns
`include "uart_settings.svh"

module uart (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_tx_start,  // one clock strobe
	input  logic [`UART_DATA_WIDTH-1:0] i_tx_data,
	output logic                        o_tx_busy,
	output logic                        o_serial,
	input  logic                        i_serial,  // kept apart from o_serial
	output logic                        o_rx_valid,
	output uart_pkg::rx_result_t        o_rx
);

	logic baud_tick;  // tx pacing only

	baud_tick_gen u_baud (
		.clk    (clk),
		.reset  (reset),
		.o_tick (baud_tick)
	);

	uart_tx u_tx (
		.clk      (clk),
		.reset    (reset),
		.i_tick   (baud_tick),
		.i_start  (i_tx_start),
		.i_data   (i_tx_data),
		.o_busy   (o_tx_busy),
		.o_serial (o_serial)
	);

	// rx keeps its own oversample count
	uart_rx u_rx (
		.clk      (clk),
		.reset    (reset),
		.i_serial (i_serial),
		.o_valid  (o_rx_valid),
		.o_result (o_rx)
	);

endmodule

//--- src/uart_pkg.sv
`include "uart_settings.svh"

package uart_pkg;

	// tx shift register load word, shifted out from bit 0
	typedef struct packed {
		logic                        stop;
		logic                        parity;  // carries the stop level when parity is off
		logic [`UART_DATA_WIDTH-1:0] data;
	} tx_frame_t;

	typedef struct packed {
		logic [`UART_DATA_WIDTH-1:0] data;
		logic                        parity_err;  // recomputed parity mismatch
		logic                        frame_err;   // stop sample was low
	} rx_result_t;

	typedef enum logic [2:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_parity,
		rx_stop
	} rx_state_t;

endpackage

//--- src/uart_rx.sv
`timescale 1ns/1ns
`include "uart_settings.svh"

module uart_rx (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_serial,
	output logic                 o_valid,
	output uart_pkg::rx_result_t o_result
);

	localparam int W = `UART_DATA_WIDTH;
	localparam int SYNC = `UART_SYNC_STAGES;
	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int CNT_W = (CLKS > 2) ? $clog2(CLKS) : 1;
	localparam int IDX_W = $clog2(W + 1);
	localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(CLKS - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS / 2 - 1);
	localparam logic PAR_EN = 1'(`UART_PARITY_EN);
	localparam logic PAR_ODD = 1'(`UART_PARITY_ODD);

	logic [SYNC-1:0]      sync_q;
	logic                 line;  // synchronized serial input
	logic                 line_q;
	logic                 fall;
	uart_pkg::rx_state_t  state_q;
	logic [CNT_W-1:0]     os_cnt;  // oversample count within a bit
	logic [IDX_W-1:0]     bit_idx;
	logic [W-1:0]         data_q;
	logic                 parity_q;
	logic                 sample;
	logic                 valid_q;
	uart_pkg::rx_result_t result_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= '1;  // preset to idle level
			line_q <= 1'b1;
		end else begin
			sync_q <= {sync_q[SYNC-2:0], i_serial};
			line_q <= line;
		end
	end

	assign line = sync_q[SYNC-1];
	assign fall = line_q && !line;

	// half a bit to mid-start, then full bits
	assign sample = (state_q == uart_pkg::rx_start) ? (os_cnt == HALF_LAST)
	                                                : (os_cnt == FULL_LAST);

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= uart_pkg::rx_idle;
			os_cnt  <= '0;
			bit_idx <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			os_cnt  <= sample ? '0 : os_cnt + 1'b1;
			case (state_q)
				uart_pkg::rx_idle: begin
					os_cnt  <= '0;  // align count to the start edge
					bit_idx <= '0;
					if (fall) begin
						state_q <= uart_pkg::rx_start;
					end
				end
				uart_pkg::rx_start: begin
					if (sample) begin
						if (line) begin
							state_q <= uart_pkg::rx_idle;  // glitch, not a start bit
						end else begin
							state_q <= uart_pkg::rx_data;
						end
					end
				end
				uart_pkg::rx_data: begin
					if (sample) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == IDX_W'(W - 1)) begin
							if (PAR_EN) begin
								state_q <= uart_pkg::rx_parity;
							end else begin
								state_q <= uart_pkg::rx_stop;
							end
						end
					end
				end
				uart_pkg::rx_parity: begin
					if (sample) begin
						state_q <= uart_pkg::rx_stop;
					end
				end
				uart_pkg::rx_stop: begin
					if (sample) begin
						valid_q <= 1'b1;
						state_q <= uart_pkg::rx_idle;
					end
				end
				default: state_q <= uart_pkg::rx_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (sample && state_q == uart_pkg::rx_data) begin
			data_q <= {line, data_q[W-1:1]};  // lsb arrives first
		end
		if (sample && state_q == uart_pkg::rx_parity) begin
			parity_q <= line;
		end
		if (sample && state_q == uart_pkg::rx_stop) begin
			result_q.data       <= data_q;
			result_q.parity_err <= PAR_EN && (((^data_q) ^ PAR_ODD) != parity_q);
			result_q.frame_err  <= !line;
		end
	end

	assign o_valid  = valid_q;
	assign o_result = result_q;

	assert property (@(posedge clk) disable iff (reset)
		o_valid |-> ($past(state_q) == uart_pkg::rx_stop) && (state_q == uart_pkg::rx_idle))
		else $error("rx valid outside stop exit");

	assert property (@(posedge clk) disable iff (reset) o_valid |=> !o_valid)
		else $error("rx valid longer than one clock");

	assert property (@(posedge clk) disable iff (reset) bit_idx <= IDX_W'(W))
		else $error("rx bit index past data width");

endmodule

//--- src/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

`define UART_DATA_WIDTH   8  // data bits per frame
`define UART_PARITY_EN    1  // 1 adds a parity bit
`define UART_PARITY_ODD   0  // 0 even, 1 odd

// bit period in system clocks, shared by tx tick and rx oversampling
`define UART_CLKS_PER_BIT 8

`define UART_SYNC_STAGES  3  // rx input synchronizer depth

`endif

//--- src/uart_tx.sv
`timescale 1ns/1ns
`include "uart_settings.svh"

module uart_tx (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_tick,
	input  logic                        i_start,
	input  logic [`UART_DATA_WIDTH-1:0] i_data,
	output logic                        o_busy,
	output logic                        o_serial
);

	localparam int W = `UART_DATA_WIDTH;
	localparam int FRAME_BITS = W + `UART_PARITY_EN + 2;  // start, data, parity, stop
	localparam int FRAME_CLKS = FRAME_BITS * `UART_CLKS_PER_BIT;  // frame length in clocks
	localparam int CNT_W = $clog2(FRAME_BITS + 1);
	localparam int SHIFT_W = $bits(uart_pkg::tx_frame_t);
	localparam logic PAR_EN = 1'(`UART_PARITY_EN);
	localparam logic PAR_ODD = 1'(`UART_PARITY_ODD);

	uart_pkg::tx_frame_t frame_q;  // latched on accept
	logic [SHIFT_W-1:0]  shift_q;
	logic [CNT_W-1:0]    bit_cnt;
	logic                busy_q;
	logic                pending_q;  // waiting for the first tick
	logic                serial_q;
	logic                accept;
	logic                parity_bit;

	assign accept = i_start && !busy_q;  // strobes while busy are dropped
	assign parity_bit = PAR_EN ? ((^i_data) ^ PAR_ODD) : 1'b1;

	always_ff @(posedge clk) begin
		if (accept) begin
			frame_q.stop   <= 1'b1;
			frame_q.parity <= parity_bit;
			frame_q.data   <= i_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q    <= 1'b0;
			pending_q <= 1'b0;
			serial_q  <= 1'b1;  // line idles high
			bit_cnt   <= '0;
		end else if (accept) begin
			busy_q    <= 1'b1;
			pending_q <= 1'b1;
			bit_cnt   <= '0;
		end else if (busy_q && i_tick) begin
			if (pending_q) begin
				pending_q <= 1'b0;
				serial_q  <= 1'b0;  // start bit
				bit_cnt   <= CNT_W'(1);
			end else if (bit_cnt == CNT_W'(FRAME_BITS)) begin
				busy_q   <= 1'b0;  // end of stop bit
				serial_q <= 1'b1;
			end else begin
				serial_q <= shift_q[0];
				bit_cnt  <= bit_cnt + 1'b1;
			end
		end
	end

	// ones fill in behind the frame so the line rests high
	always_ff @(posedge clk) begin
		if (busy_q && i_tick) begin
			if (pending_q) begin
				shift_q <= frame_q;
			end else begin
				shift_q <= {1'b1, shift_q[SHIFT_W-1:1]};
			end
		end
	end

	assign o_busy   = busy_q;
	assign o_serial = serial_q;

	assert property (@(posedge clk) disable iff (reset) !o_busy |-> o_serial)
		else $error("tx line low while not busy");

	// busy drops one whole frame after the start bit went out
	assert property (@(posedge clk) disable iff (reset)
		$fell(busy_q) |-> $past(pending_q, FRAME_CLKS + 1) && !$past(pending_q, FRAME_CLKS))
		else $error("tx busy dropped before frame end");

	cover property (@(posedge clk) disable iff (reset) i_start && busy_q);

endmodule

//--- tb/uart_model.svh
`ifndef UART_MODEL_SVH
`define UART_MODEL_SVH

uart_pkg::rx_result_t exp_q[$];  // expected receive results, oldest first

// xor of the data bits, inverted for odd parity
function automatic logic expected_parity(input logic [`UART_DATA_WIDTH-1:0] data);
	return (^data) ^ 1'(`UART_PARITY_ODD);
endfunction

// line level of frame bit idx, start bit is idx 0
function automatic logic frame_bit(input logic [`UART_DATA_WIDTH-1:0] data, input int idx);
	if (idx == 0) begin
		return 1'b0;
	end
	if (idx <= `UART_DATA_WIDTH) begin
		return data[idx-1];  // lsb first
	end
	if (`UART_PARITY_EN && idx == `UART_DATA_WIDTH + 1) begin
		return expected_parity(data);
	end
	return 1'b1;  // stop
endfunction

task automatic push_expected(input logic [`UART_DATA_WIDTH-1:0] data, input logic par,
                             input logic stop);
	uart_pkg::rx_result_t r;
	r.data = data;
	r.parity_err = `UART_PARITY_EN && (par != expected_parity(data));
	r.frame_err = !stop;
	exp_q.push_back(r);
endtask

task automatic check_result(input uart_pkg::rx_result_t got);
	uart_pkg::rx_result_t want;
	want = exp_q.pop_front();
	if (got !== want) begin
		abort_run($sformatf("CHECK FAILED at %0t: rx data %h pe %b fe %b, expected %h pe %b fe %b",
			$time, got.data, got.parity_err, got.frame_err,
			want.data, want.parity_err, want.frame_err));
	end
endtask

task automatic check_bit(input logic got, input logic want, input string what);
	if (got !== want) begin
		abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, want));
	end
endtask

`endif

//--- tb/tb_uart.sv
`timescale 1ns/1ns
`include "uart_settings.svh"

module tb_uart;

	localparam int DW = `UART_DATA_WIDTH;
	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int FRAME_BITS = DW + `UART_PARITY_EN + 2;
	localparam int TIMEOUT_CYCLES = 40 * FRAME_BITS * CLKS * 2 + 2000;  // 40 frames, twice over

	logic                 clk;
	logic                 reset;
	logic                 i_tx_start;
	logic [DW-1:0]        i_tx_data;
	logic                 o_tx_busy;
	logic                 o_serial;
	logic                 i_serial;
	logic                 o_rx_valid;
	uart_pkg::rx_result_t o_rx;
	logic                 loop_sel;  // 1 feeds o_serial back in
	logic                 inj_line;
	integer               seed;
	int                   cycles = 0;
	int                   rx_count = 0;

	assign i_serial = loop_sel ? o_serial : inj_line;

	uart u_uart (
		.clk        (clk),
		.reset      (reset),
		.i_tx_start (i_tx_start),
		.i_tx_data  (i_tx_data),
		.o_tx_busy  (o_tx_busy),
		.o_serial   (o_serial),
		.i_serial   (i_serial),
		.o_rx_valid (o_rx_valid),
		.o_rx       (o_rx)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped at first error");
	endtask

	`include "uart_model.svh"

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
		end
	end

	// outputs only move on posedge
	always @(negedge clk) begin
		if (!reset && o_rx_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("receiver gave a result that no sent frame accounts for");
			end else begin
				check_result(o_rx);
				rx_count++;
			end
		end
	end

	task automatic start_tx(input logic [DW-1:0] data);
		while (o_tx_busy) begin
			@(negedge clk);
		end
		push_expected(data, expected_parity(data), 1'b1);
		i_tx_start = 1'b1;
		i_tx_data = data;
		@(negedge clk);
		i_tx_start = 1'b0;
		check_bit(o_tx_busy, 1'b1, "tx busy after accepted start");
	endtask

	task automatic check_frame_shape(input logic [DW-1:0] data);
		int idx;
		start_tx(data);
		while (o_serial !== 1'b0) begin
			@(negedge clk);
		end
		repeat (CLKS / 2) @(negedge clk);  // mid start bit
		for (idx = 0; idx < FRAME_BITS; idx++) begin
			check_bit(o_serial, frame_bit(data, idx), $sformatf("frame bit %0d", idx));
			check_bit(o_tx_busy, 1'b1, "tx busy during frame");
			repeat (CLKS) @(negedge clk);
		end
	endtask

	task automatic inject_frame(input logic [DW-1:0] data, input logic par, input logic stop);
		int idx;
		push_expected(data, par, stop);
		for (idx = 0; idx < FRAME_BITS; idx++) begin
			if (idx == 0) begin
				inj_line = 1'b0;
			end else if (idx <= DW) begin
				inj_line = data[idx-1];
			end else if (idx == FRAME_BITS - 1) begin
				inj_line = stop;
			end else begin
				inj_line = par;
			end
			repeat (CLKS) @(negedge clk);
		end
		inj_line = 1'b1;
		repeat (2 * CLKS) @(negedge clk);  // idle gap lets rx leave a low stop
	endtask

	task automatic wait_idle();
		while (o_tx_busy || exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	initial begin
		logic [DW-1:0] data;
		int n;
		seed = 86;
		reset = 1'b1;
		i_tx_start = 1'b0;
		i_tx_data = '0;
		loop_sel = 1'b1;
		inj_line = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		check_bit(o_serial, 1'b1, "serial line after reset");
		check_bit(o_tx_busy, 1'b0, "tx busy after reset");
		repeat (50) begin
			@(negedge clk);
			check_bit(o_rx_valid, 1'b0, "rx valid while idle");
		end

		for (n = 0; n < 24; n++) begin
			data = DW'($random(seed));
			start_tx(data);  // back to back in loopback
		end
		wait_idle();

		for (n = 0; n < 6; n++) begin
			data = DW'($random(seed));
			check_frame_shape(data);
		end
		wait_idle();

		loop_sel = 1'b0;  // rx now hears the injector
		for (n = 0; n < 3; n++) begin
			data = DW'($random(seed));
			inject_frame(data, !expected_parity(data), 1'b1);
		end
		for (n = 0; n < 2; n++) begin
			data = DW'($random(seed));
			inject_frame(data, expected_parity(data), 1'b0);
			data = DW'($random(seed));
			inject_frame(data, expected_parity(data), 1'b1);  // recovery frame
		end
		wait_idle();
		loop_sel = 1'b1;

		// second strobe while busy must be dropped
		data = DW'($random(seed));
		start_tx(data);
		repeat (CLKS) @(negedge clk);
		check_bit(o_tx_busy, 1'b1, "tx busy before second strobe");
		i_tx_start = 1'b1;
		i_tx_data = DW'($random(seed));
		@(negedge clk);
		i_tx_start = 1'b0;
		wait_idle();
		repeat (2 * FRAME_BITS * CLKS) begin
			@(negedge clk);
			check_bit(o_tx_busy, 1'b0, "tx busy after ignored strobe");
			check_bit(o_serial, 1'b1, "serial line after ignored strobe");
		end

		if (exp_q.size() != 0) begin
			abort_run($sformatf("%0d expected results never arrived", exp_q.size()));
		end else if (rx_count == 0) begin
			abort_run("no receive results were seen at all");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule
